//--- build.f
+incdir+common
common/spi_regs_pkg.sv
spi_slave/spi_slave_shifter.sv
rtl/spi_cmd_decoder.sv
rtl/spi_reg_bank.sv
rtl/spi_response_builder.sv
rtl/spi_regs_top.sv
dv/spi_regs_tb.sv

//--- common/spi_regs_defs.svh
`ifndef SPI_REGS_DEFS_SVH
`define SPI_REGS_DEFS_SVH

// Frame width in SCLK edges
`define SPI_FRAME_BITS 16

// Implemented registers, higher addresses are invalid
`define SPI_REG_COUNT 6

// Field positions within a frame
// Bits 10 to 8 are reserved
`define SPI_OP_MSB   15
`define SPI_ADDR_MSB 13
`define SPI_DATA_MSB 7

`endif

//--- common/spi_regs_pkg.sv
`include "spi_regs_defs.svh"

package spi_regs_pkg;

    // Frame opcodes
    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,
        OP_WRITE    = 2'd1,
        OP_READ     = 2'd2,
        // ORs the data byte into the register
        OP_SET_BITS = 2'd3
    } spi_op_e;

    // Slave shifter states
    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        TRANSFER      = 2'd1,
        WAIT_DEASSERT = 2'd2
    } spi_state_e;

    // Decoded command, decoder to register bank
    typedef struct packed {
        spi_op_e                op;
        logic [2:0]             addr;
        logic [`SPI_DATA_MSB:0] wdata;
        logic                   bad_addr;
    } spi_cmd_t;

    // Executed command, register bank to response builder
    typedef struct packed {
        spi_op_e                op;
        logic [2:0]             addr;
        logic                   error;
        logic [`SPI_DATA_MSB:0] rdata;
    } spi_result_t;

endpackage

//--- dv/spi_regs_tb.sv
`timescale 1ns/1ns
`include "spi_regs_defs.svh"

module spi_regs_tb
    import spi_regs_pkg::*;
();

    // About 45 frames of roughly 160 clocks plus margin
    localparam int CYCLE_LIMIT = 12000;

    logic clock;
    logic reset;
    logic sclk;
    logic ss;
    logic mosi;
    logic clock_polarity;
    logic latching_edge;
    logic msb_first;
    logic ss_polarity;
    logic enable;
    logic miso;
    logic [`SPI_DATA_MSB:0] reg0;

    // Mode applied in the gap after the next frame
    logic next_cpol;
    logic next_le;
    logic next_msb;
    logic next_sspol;

    logic [15:0] lfsr_state = 16'd87;
    int          cycle_count = 0;

    // Reference model
    logic [`SPI_DATA_MSB:0]  model_regs [`SPI_REG_COUNT];
    logic [1:0]              model_seq;
    logic [`SPI_FRAME_BITS-1:0] expected_word;

    spi_state_e shifter_state;
    assign shifter_state = dut0.u_shifter.state;

    spi_regs_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .sclk           (sclk),
        .ss             (ss),
        .mosi           (mosi),
        .clock_polarity (clock_polarity),
        .latching_edge  (latching_edge),
        .msb_first      (msb_first),
        .ss_polarity    (ss_polarity),
        .enable         (enable),
        .miso           (miso),
        .reg0           (reg0)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_on_failure($sformatf("Timeout: run exceeded %0d clocks, shifter state %s",
                                      CYCLE_LIMIT, shifter_state.name()));
        end
    end

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [15:0] make_word(input spi_op_e op, input logic [2:0] addr,
                                              input logic [7:0] data);
        return {op, addr, 3'b000, data};
    endfunction

    // Applies one command to the model and returns the expected response word
    function automatic logic [15:0] predict_response(input logic [15:0] word);
        spi_op_e    op;
        logic [2:0] addr;
        logic [7:0] data;
        logic       err;
        logic [7:0] rdata;
        logic [15:0] resp;
        op    = spi_op_e'(word[`SPI_OP_MSB -: 2]);
        addr  = word[`SPI_ADDR_MSB -: 3];
        data  = word[`SPI_DATA_MSB:0];
        err   = (addr >= `SPI_REG_COUNT) && (op != OP_NOP);
        rdata = 8'h00;
        if (!err && (addr < `SPI_REG_COUNT)) begin
            case (op)
                OP_WRITE: begin
                    model_regs[addr] = data;
                    rdata = data;
                end
                OP_READ: rdata = model_regs[addr];
                OP_SET_BITS: begin
                    model_regs[addr] = model_regs[addr] | data;
                    rdata = model_regs[addr];
                end
                default: rdata = 8'h00;
            endcase
        end
        resp = {op, addr, err, model_seq, rdata};
        model_seq = model_seq + 2'd1;
        return resp;
    endfunction

    task automatic select_mode(input logic cpol, input logic le, input logic msb,
                               input logic sspol);
        next_cpol  = cpol;
        next_le    = le;
        next_msb   = msb;
        next_sspol = sspol;
    endtask

    // SPI master model with SCLK toggling every 4 clocks
    task automatic spi_transfer(input logic [15:0] word, output logic [15:0] captured);
        int pos;
        captured = '0;
        pos = msb_first ? 15 : 0;
        @(posedge clock);
        ss   <= ~ss_polarity;
        mosi <= word[pos];
        repeat (4) @(posedge clock);
        for (int i = 0; i < 16; i++) begin
            pos = msb_first ? 15 - i : i;
            if (latching_edge) begin
                sclk <= ~sclk;
                mosi <= word[pos];
                repeat (4) @(posedge clock);
            end
            // Sampling edge
            captured[pos] = miso;
            sclk <= ~sclk;
            repeat (4) @(posedge clock);
            if (!latching_edge) begin
                sclk <= ~sclk;
                if (i < 15) begin
                    mosi <= word[msb_first ? 14 - i : i + 1];
                end
                repeat (4) @(posedge clock);
            end
        end
        ss <= ss_polarity;
        // New mode lands after the frame is captured and before the response latch
        repeat (2) @(posedge clock);
        clock_polarity <= next_cpol;
        latching_edge  <= next_le;
        msb_first      <= next_msb;
        ss_polarity    <= next_sspol;
        sclk           <= next_cpol;
        ss             <= next_sspol;
        repeat (18) @(posedge clock);
    endtask

    task automatic run_frame(input logic [15:0] word, output logic [15:0] captured);
        logic enabled;
        spi_transfer(word, captured);
        enabled = enable;
        if (enabled) begin
            assert (captured == expected_word) else begin
                stop_on_failure($sformatf("ERROR at %0t: frame %h got response %h, expected %h",
                                          $time, word, captured, expected_word));
            end
            expected_word = predict_response(word);
        end
        assert (reg0 == model_regs[0]) else begin
            stop_on_failure($sformatf("ERROR at %0t: reg0 is %h, expected %h",
                                      $time, reg0, model_regs[0]));
        end
    endtask

    task automatic check_response(input logic [15:0] resp, input logic err,
                                  input logic [7:0] rdata, input string what);
        assert ((resp[10] == err) && (resp[7:0] == rdata)) else begin
            stop_on_failure($sformatf("ERROR at %0t: %s gave error %b data %h, expected %b %h",
                                      $time, what, resp[10], resp[7:0], err, rdata));
        end
    endtask

    initial begin
        logic [15:0] resp;
        logic [3:0]  mode;
        reset          <= 1'b0;
        sclk           <= 1'b0;
        ss             <= 1'b0;
        mosi           <= 1'b0;
        clock_polarity <= 1'b0;
        latching_edge  <= 1'b0;
        msb_first      <= 1'b0;
        ss_polarity    <= 1'b0;
        enable         <= 1'b1;
        select_mode(1'b0, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < `SPI_REG_COUNT; i++) begin
            model_regs[i] = 8'h00;
        end
        model_seq     = 2'd0;
        expected_word = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        repeat (4) @(posedge clock);

        // Write then read back
        run_frame(make_word(OP_WRITE, 3'd2, 8'hA5), resp);
        run_frame(make_word(OP_READ, 3'd2, 8'h00), resp);
        run_frame(make_word(OP_NOP, 3'd0, 8'h00), resp);
        check_response(resp, 1'b0, 8'hA5, "read of register 2");

        // Set bits on register 0
        run_frame(make_word(OP_WRITE, 3'd0, 8'h30), resp);
        run_frame(make_word(OP_SET_BITS, 3'd0, 8'h03), resp);
        run_frame(make_word(OP_NOP, 3'd0, 8'h00), resp);
        check_response(resp, 1'b0, 8'h33, "set bits on register 0");

        // Invalid addresses
        run_frame(make_word(OP_WRITE, 3'd6, 8'hFF), resp);
        run_frame(make_word(OP_SET_BITS, 3'd7, 8'hFF), resp);
        check_response(resp, 1'b1, 8'h00, "write to address 6");
        run_frame(make_word(OP_READ, 3'd2, 8'h00), resp);
        check_response(resp, 1'b1, 8'h00, "set bits on address 7");
        run_frame(make_word(OP_NOP, 3'd0, 8'h00), resp);
        check_response(resp, 1'b0, 8'hA5, "read after bad addresses");

        // Random frames stepping through all sixteen modes
        for (int i = 0; i < 30; i++) begin
            mode = 4'(i + 1);
            select_mode(mode[3], mode[2], mode[1], mode[0]);
            run_frame(random_bits(16), resp);
        end

        // Disabled frames are ignored
        @(posedge clock);
        enable <= 1'b0;
        run_frame(make_word(OP_WRITE, 3'd0, 8'hFF), resp);
        run_frame(make_word(OP_SET_BITS, 3'd1, 8'h5A), resp);
        @(posedge clock);
        enable <= 1'b1;
        run_frame(make_word(OP_READ, 3'd0, 8'h00), resp);
        run_frame(make_word(OP_READ, 3'd1, 8'h00), resp);
        run_frame(make_word(OP_NOP, 3'd0, 8'h00), resp);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- rtl/spi_cmd_decoder.sv
`timescale 1ns/1ns
`include "spi_regs_defs.svh"

module spi_cmd_decoder
    import spi_regs_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic [`SPI_FRAME_BITS-1:0] rx_word,
    input  logic                       rx_valid,
    output spi_cmd_t                   cmd,
    output logic                       cmd_valid
);

    spi_op_e                op_field;
    logic [2:0]             addr_field;
    logic [`SPI_DATA_MSB:0] data_field;
    logic                   addr_invalid;

    // Field extraction, reserved bits dropped
    always_comb begin
        op_field   = spi_op_e'(rx_word[`SPI_OP_MSB -: $bits(spi_op_e)]);
        addr_field = rx_word[`SPI_ADDR_MSB -: 3];
        data_field = rx_word[`SPI_DATA_MSB:0];
    end

    // A NOP never touches a register, so any address is fine for it
    assign addr_invalid = (addr_field >= `SPI_REG_COUNT) && (op_field != OP_NOP);

    always_ff @(posedge clock) begin
        if (!reset) begin
            cmd       <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= rx_valid;
            if (rx_valid) begin
                cmd.op       <= op_field;
                cmd.addr     <= addr_field;
                cmd.wdata    <= data_field;
                cmd.bad_addr <= addr_invalid;
            end
        end
    end

endmodule

//--- rtl/spi_reg_bank.sv
`timescale 1ns/1ns
`include "spi_regs_defs.svh"

module spi_reg_bank
    import spi_regs_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  spi_cmd_t               cmd,
    input  logic                   cmd_valid,
    output spi_result_t            result,
    output logic                   result_valid,
    output logic [`SPI_DATA_MSB:0] reg0
);

    logic [`SPI_DATA_MSB:0] regs [`SPI_REG_COUNT];

    logic                   addr_ok;
    logic                   reg_wr;
    logic [`SPI_DATA_MSB:0] cur_val;
    logic [`SPI_DATA_MSB:0] next_val;
    logic [`SPI_DATA_MSB:0] rdata;

    always_comb begin
        // Guards the array read for NOPs aimed at unused addresses
        addr_ok = (cmd.addr < `SPI_REG_COUNT);
        cur_val = addr_ok ? regs[cmd.addr] : '0;

        case (cmd.op)
            OP_WRITE:    next_val = cmd.wdata;
            OP_SET_BITS: next_val = cur_val | cmd.wdata;
            default:     next_val = cur_val;
        endcase

        reg_wr = cmd_valid && addr_ok && !cmd.bad_addr &&
                 ((cmd.op == OP_WRITE) || (cmd.op == OP_SET_BITS));

        // Value after the operation, zero for NOP and bad addresses
        if (cmd.bad_addr || !addr_ok || (cmd.op == OP_NOP)) begin
            rdata = '0;
        end else begin
            rdata = next_val;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `SPI_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= cmd_valid;
            if (cmd_valid) begin
                result.op    <= cmd.op;
                result.addr  <= cmd.addr;
                result.error <= cmd.bad_addr;
                result.rdata <= rdata;
            end
            if (reg_wr) begin
                regs[cmd.addr] <= next_val;
            end
        end
    end

    // Register 0 doubles as a control output
    assign reg0 = regs[0];

endmodule

//--- rtl/spi_regs_top.sv
`timescale 1ns/1ns
`include "spi_regs_defs.svh"

module spi_regs_top
    import spi_regs_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   sclk,
    input  logic                   ss,
    input  logic                   mosi,
    input  logic                   clock_polarity,
    input  logic                   latching_edge,
    input  logic                   msb_first,
    input  logic                   ss_polarity,
    input  logic                   enable,
    output logic                   miso,
    output logic [`SPI_DATA_MSB:0] reg0
);

    logic [`SPI_FRAME_BITS-1:0] rx_word;
    logic                       rx_valid;
    spi_cmd_t                   cmd;
    logic                       cmd_valid;
    spi_result_t                result;
    logic                       result_valid;
    logic [`SPI_FRAME_BITS-1:0] tx_word;
    logic                       tx_valid;

    // Pin side, frames in and responses out
    spi_slave_shifter u_shifter (
        .clock          (clock),
        .reset          (reset),
        .sclk           (sclk),
        .ss             (ss),
        .mosi           (mosi),
        .clock_polarity (clock_polarity),
        .latching_edge  (latching_edge),
        .msb_first      (msb_first),
        .ss_polarity    (ss_polarity),
        .enable         (enable),
        .tx_word        (tx_word),
        .tx_valid       (tx_valid),
        .miso           (miso),
        .rx_word        (rx_word),
        .rx_valid       (rx_valid)
    );

    spi_cmd_decoder u_decoder (
        .clock     (clock),
        .reset     (reset),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    spi_reg_bank u_bank (
        .clock        (clock),
        .reset        (reset),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .result       (result),
        .result_valid (result_valid),
        .reg0         (reg0)
    );

    // Response lands in the shifter three clocks after rx_valid
    spi_response_builder u_builder (
        .clock        (clock),
        .reset        (reset),
        .result       (result),
        .result_valid (result_valid),
        .tx_word      (tx_word),
        .tx_valid     (tx_valid)
    );

endmodule

//--- rtl/spi_response_builder.sv
`timescale 1ns/1ns
`include "spi_regs_defs.svh"

module spi_response_builder
    import spi_regs_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  spi_result_t                result,
    input  logic                       result_valid,
    output logic [`SPI_FRAME_BITS-1:0] tx_word,
    output logic                       tx_valid
);

    // Frame sequence count, wraps every four results
    logic [1:0] seq_cnt;

    logic [`SPI_FRAME_BITS-1:0] resp_word;

    // Opcode, address, error, sequence, read data from MSB down
    assign resp_word = {result.op, result.addr, result.error, seq_cnt, result.rdata};

    always_ff @(posedge clock) begin
        if (!reset) begin
            seq_cnt  <= 2'd0;
            tx_word  <= '0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= result_valid;
            if (result_valid) begin
                tx_word <= resp_word;
                seq_cnt <= seq_cnt + 2'd1;
            end
        end
    end

endmodule

//--- spi_slave/spi_slave_shifter.sv
`timescale 1ns/1ns
`include "spi_regs_defs.svh"

module spi_slave_shifter
    import spi_regs_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       sclk,
    input  logic                       ss,
    input  logic                       mosi,
    input  logic                       clock_polarity,
    input  logic                       latching_edge,
    input  logic                       msb_first,
    input  logic                       ss_polarity,
    input  logic                       enable,
    input  logic [`SPI_FRAME_BITS-1:0] tx_word,
    input  logic                       tx_valid,
    output logic                       miso,
    output logic [`SPI_FRAME_BITS-1:0] rx_word,
    output logic                       rx_valid
);

    localparam int CNT_BITS = $clog2(`SPI_FRAME_BITS);

    // Bit reversal for MSB-first transfers
    function automatic logic [`SPI_FRAME_BITS-1:0] reverse_word(
        input logic [`SPI_FRAME_BITS-1:0] word
    );
        logic [`SPI_FRAME_BITS-1:0] rev;
        for (int i = 0; i < `SPI_FRAME_BITS; i++) begin
            rev[i] = word[`SPI_FRAME_BITS-1-i];
        end
        return rev;
    endfunction

    spi_state_e state;

    logic inner_ss;
    logic inner_sclk;
    logic ss_del;
    logic sclk_del;
    logic ss_polarity_del;

    logic ss_start;
    logic ss_end;
    logic sclk_rise;
    logic sclk_fall;
    logic last_bit;

    logic [CNT_BITS-1:0]        bit_cnt;
    logic [`SPI_FRAME_BITS-1:0] shift_reg;
    logic [`SPI_FRAME_BITS-1:0] tx_latched;

    // Conditioned SS is high while selected
    // Conditioned SCLK rises on the sampling edge in all four modes
    always_comb begin
        inner_ss   = ss_polarity ? ~ss : ss;
        inner_sclk = sclk ^ (clock_polarity ^ latching_edge);
    end

    // No frame start in the clock where the SS polarity flipped
    assign ss_start  = enable && inner_ss && !ss_del && (ss_polarity == ss_polarity_del);
    assign ss_end    = !inner_ss && ss_del;
    assign sclk_rise = inner_sclk && !sclk_del;
    assign sclk_fall = !inner_sclk && sclk_del;
    assign last_bit  = (bit_cnt == CNT_BITS'(`SPI_FRAME_BITS - 1));

    always_ff @(posedge clock) begin
        if (!reset) begin
            state           <= IDLE;
            ss_del          <= 1'b0;
            sclk_del        <= 1'b0;
            ss_polarity_del <= 1'b0;
            bit_cnt         <= '0;
            shift_reg       <= '0;
            tx_latched      <= '0;
            miso            <= 1'b0;
            rx_word         <= '0;
            rx_valid        <= 1'b0;
        end else begin
            ss_del          <= inner_ss;
            sclk_del        <= inner_sclk;
            ss_polarity_del <= ss_polarity;
            rx_valid        <= 1'b0;

            case (state)
                IDLE: begin
                    // Response word only taken between frames
                    if (tx_valid) begin
                        tx_latched <= msb_first ? reverse_word(tx_word) : tx_word;
                    end
                    if (ss_start) begin
                        state     <= TRANSFER;
                        bit_cnt   <= '0;
                        shift_reg <= '0;
                        miso      <= tx_latched[0];
                    end
                end

                TRANSFER: begin
                    if (sclk_rise) begin
                        shift_reg[bit_cnt] <= mosi;
                        bit_cnt            <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= WAIT_DEASSERT;
                        end
                    end
                    if (sclk_fall) begin
                        miso <= tx_latched[bit_cnt];
                    end
                end

                WAIT_DEASSERT: begin
                    if (ss_end) begin
                        rx_word  <= msb_first ? reverse_word(shift_reg) : shift_reg;
                        rx_valid <= 1'b1;
                        state    <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule
